/* Makefile */
# Verilator flow for the m_cu store path
VERILATOR ?= verilator
TOP       ?= tb_m_cu
FLIST     ?= m_cu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
FAIL_MSG  ?= === FAIL ===

SRCS := $(filter-out +%,$(shell cat $(FLIST))) mcu_macros.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* emul_calc.sv */
// Effective LMUL calculation
`timescale 1ns/1ps
`include "mcu_macros.svh"

module emul_calc
  import vec_cfg_pkg::*;
(
  input  vcfg_t width_i,
  input  vcfg_t lmul_i,
  input  vcfg_t sew_i,
  output vcfg_t emul_o
);

  localparam signed [4:0] LOG_MAX   = `MCU_EMUL_LOG_MAX;
  localparam signed [4:0] LOG_MIN   = -LOG_MAX;
  localparam vcfg_t       LMUL_RSVD = 3'b100;

  emul_addr_u        addr;
  logic signed [4:0] log_emul;
  logic              legal;

  // Packed as the EMUL table address
  assign addr.index = {width_i[1:0], lmul_i, sew_i[1:0]};

  // log2 EMUL = log2 LMUL + width - sew
  assign log_emul = $signed({{2{addr.fields.lmul[2]}}, addr.fields.lmul})
                  + $signed({3'b000, addr.fields.width})
                  - $signed({3'b000, addr.fields.sew});

  assign legal = (width_i < 3'd3) && (sew_i < 3'd3) &&
                 (lmul_i != LMUL_RSVD) &&
                 (log_emul >= LOG_MIN) && (log_emul <= LOG_MAX);

  // Illegal combinations read as code 0
  assign emul_o = legal ? log_emul[2:0] : '0;

endmodule : emul_calc

/* m_cu.f */
+incdir+.
vec_cfg_pkg.sv
store_ctrl_pkg.sv
emul_calc.sv
store_read_pipe.sv
store_fsm.sv
m_cu.sv
tb_clk_gen.sv
tb_m_cu.sv

/* m_cu.sv */
// Memory control unit store path
`timescale 1ns/1ps

module m_cu
  import vec_cfg_pkg::*;
  import store_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // Scheduler interface
  input  logic        mcu_st_vld_i,
  input  vcfg_t       mcu_sew_i,
  input  vcfg_t       mcu_lmul_i,
  input  vcfg_t       mcu_data_width_i,
  input  logic        mcu_unit_ld_st_i,
  input  logic        mcu_strided_ld_st_i,
  input  logic        mcu_idx_ld_st_i,
  // Lanes, buffer and AXI master
  input  logic        vlane_store_valid_i,
  input  logic        sbuff_write_done_i,
  input  logic        sbuff_read_done_i,
  input  logic        ctrl_wdone_i,
  input  logic        wr_tready_i,
  output logic        mcu_st_rdy_o,
  // Buffer array configuration
  output vcfg_t       cfg_store_data_sew_o,
  output vcfg_t       cfg_store_data_lmul_o,
  output vcfg_t       cfg_store_idx_sew_o,
  output vcfg_t       cfg_store_idx_lmul_o,
  output store_kind_t store_type_o,
  output logic        cfg_store_update_o,
  output logic        cfg_store_cntr_rst_o,
  // Strobes
  output logic        store_baseaddr_reset_o,
  output logic        store_baseaddr_update_o,
  output logic        sbuff_wen_o,
  output logic        sbuff_ren_o,
  output logic        sbuff_read_stall_o,
  output logic        ctrl_wstart_o,
  output logic        wr_tvalid_o
);

  vcfg_t emul;
  logic  tvalid_push;
  logic  read_stall;
  logic  read_invalidate;
  logic  stage_last;
  logic  drained;

  emul_calc u_emul_calc (
    .width_i (mcu_data_width_i),
    .lmul_i  (mcu_lmul_i),
    .sew_i   (mcu_sew_i),
    .emul_o  (emul)
  );

  store_fsm u_store_fsm (
    .clk                     (clk),
    .rstn                    (rstn),
    .mcu_st_vld_i            (mcu_st_vld_i),
    .mcu_unit_ld_st_i        (mcu_unit_ld_st_i),
    .mcu_strided_ld_st_i     (mcu_strided_ld_st_i),
    .mcu_idx_ld_st_i         (mcu_idx_ld_st_i),
    .mcu_sew_i               (mcu_sew_i),
    .mcu_lmul_i              (mcu_lmul_i),
    .mcu_data_width_i        (mcu_data_width_i),
    .emul_i                  (emul),
    .vlane_store_valid_i     (vlane_store_valid_i),
    .sbuff_write_done_i      (sbuff_write_done_i),
    .sbuff_read_done_i       (sbuff_read_done_i),
    .ctrl_wdone_i            (ctrl_wdone_i),
    .wr_tready_i             (wr_tready_i),
    .stage_last_i            (stage_last),
    .drained_i               (drained),
    .mcu_st_rdy_o            (mcu_st_rdy_o),
    .cfg_store_data_sew_o    (cfg_store_data_sew_o),
    .cfg_store_data_lmul_o   (cfg_store_data_lmul_o),
    .cfg_store_idx_sew_o     (cfg_store_idx_sew_o),
    .cfg_store_idx_lmul_o    (cfg_store_idx_lmul_o),
    .store_type_o            (store_type_o),
    .cfg_store_update_o      (cfg_store_update_o),
    .cfg_store_cntr_rst_o    (cfg_store_cntr_rst_o),
    .store_baseaddr_reset_o  (store_baseaddr_reset_o),
    .store_baseaddr_update_o (store_baseaddr_update_o),
    .sbuff_wen_o             (sbuff_wen_o),
    .sbuff_ren_o             (sbuff_ren_o),
    .sbuff_read_stall_o      (sbuff_read_stall_o),
    .ctrl_wstart_o           (ctrl_wstart_o),
    .tvalid_push_o           (tvalid_push),
    .read_stall_o            (read_stall),
    .read_invalidate_o       (read_invalidate)
  );

  store_read_pipe u_store_read_pipe (
    .clk               (clk),
    .rstn              (rstn),
    .tvalid_push_i     (tvalid_push),
    .read_stall_i      (read_stall),
    .read_invalidate_i (read_invalidate),
    .wr_tvalid_o       (wr_tvalid_o),
    .stage_last_o      (stage_last),
    .drained_o         (drained)
  );

endmodule : m_cu

/* mcu_macros.svh */
// Memory control unit macros
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// Width of SEW, LMUL, element width and EMUL codes
`define MCU_VCFG_W 3

// Store buffer read latency in cycles
`define MCU_RD_LAT 2

// Largest legal log2 EMUL
`define MCU_EMUL_LOG_MAX 3

`endif

/* store_ctrl_pkg.sv */
// Store control types
package store_ctrl_pkg;

  // One-hot store kind, as shown to the buffer array
  typedef struct packed {
    logic unit;
    logic strided;
    logic indexed;
  } store_kind_t;

  // Store sequencer states
  typedef enum logic [3:0] {
    st_idle,
    unit_prep,
    unit_tx,
    strided_prep,
    strided_tx_prep,
    strided_tx,
    indexed_prep,
    indexed_tx_prep,
    indexed_tx
  } store_state_e;

endpackage : store_ctrl_pkg

/* store_fsm.sv */
// Store sequencer
`timescale 1ns/1ps

module store_fsm
  import vec_cfg_pkg::*;
  import store_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  // Scheduler request
  input  logic        mcu_st_vld_i,
  input  logic        mcu_unit_ld_st_i,
  input  logic        mcu_strided_ld_st_i,
  input  logic        mcu_idx_ld_st_i,
  input  vcfg_t       mcu_sew_i,
  input  vcfg_t       mcu_lmul_i,
  input  vcfg_t       mcu_data_width_i,
  input  vcfg_t       emul_i,
  // Lanes, buffer and AXI master status
  input  logic        vlane_store_valid_i,
  input  logic        sbuff_write_done_i,
  input  logic        sbuff_read_done_i,
  input  logic        ctrl_wdone_i,
  input  logic        wr_tready_i,
  // Read pipe status
  input  logic        stage_last_i,
  input  logic        drained_i,
  // Scheduler ready
  output logic        mcu_st_rdy_o,
  // Buffer array configuration
  output vcfg_t       cfg_store_data_sew_o,
  output vcfg_t       cfg_store_data_lmul_o,
  output vcfg_t       cfg_store_idx_sew_o,
  output vcfg_t       cfg_store_idx_lmul_o,
  output store_kind_t store_type_o,
  output logic        cfg_store_update_o,
  output logic        cfg_store_cntr_rst_o,
  // Address generator and buffer strobes
  output logic        store_baseaddr_reset_o,
  output logic        store_baseaddr_update_o,
  output logic        sbuff_wen_o,
  output logic        sbuff_ren_o,
  output logic        sbuff_read_stall_o,
  output logic        ctrl_wstart_o,
  // Read pipe control
  output logic        tvalid_push_o,
  output logic        read_stall_o,
  output logic        read_invalidate_o
);

  store_state_e state_q;
  store_state_e state_d;
  logic         mcu_st_vld_reg;
  logic         save_cfg;
  logic         read_stall;
  store_kind_t  kind;
  vcfg_t        data_sew_d;
  vcfg_t        data_lmul_d;
  vcfg_t        idx_sew_d;
  vcfg_t        idx_lmul_d;

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mcu_st_vld_reg <= 1'b0;
    end else begin
      mcu_st_vld_reg <= mcu_st_vld_i;
    end
  end

  // Priority unit, strided, indexed
  assign kind.unit    = mcu_unit_ld_st_i;
  assign kind.strided = ~mcu_unit_ld_st_i & mcu_strided_ld_st_i;
  assign kind.indexed = ~mcu_unit_ld_st_i & ~mcu_strided_ld_st_i & mcu_idx_ld_st_i;

  // Indexed stores carry data config from the vtype, index config from the op
  always_comb begin
    idx_sew_d  = mcu_data_width_i;
    idx_lmul_d = emul_i;
    if (kind.indexed) begin
      data_sew_d  = mcu_sew_i;
      data_lmul_d = mcu_lmul_i;
    end else begin
      data_sew_d  = mcu_data_width_i;
      data_lmul_d = emul_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      store_type_o          <= '0;
      cfg_store_data_sew_o  <= '0;
      cfg_store_data_lmul_o <= '0;
      cfg_store_idx_sew_o   <= '0;
      cfg_store_idx_lmul_o  <= '0;
    end else if (save_cfg) begin
      store_type_o          <= kind;
      cfg_store_data_sew_o  <= data_sew_d;
      cfg_store_data_lmul_o <= data_lmul_d;
      cfg_store_idx_sew_o   <= idx_sew_d;
      cfg_store_idx_lmul_o  <= idx_lmul_d;
    end
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d                 = state_q;
    mcu_st_rdy_o            = 1'b0;
    save_cfg                = 1'b0;
    cfg_store_update_o      = 1'b0;
    cfg_store_cntr_rst_o    = 1'b0;
    store_baseaddr_reset_o  = 1'b0;
    store_baseaddr_update_o = 1'b0;
    sbuff_wen_o             = 1'b0;
    sbuff_ren_o             = 1'b0;
    ctrl_wstart_o           = 1'b0;
    tvalid_push_o           = 1'b0;
    read_stall              = 1'b0;
    read_invalidate_o       = 1'b0;

    case (state_q)
      st_idle: begin
        mcu_st_rdy_o = 1'b1;
        if (mcu_st_vld_reg) begin
          save_cfg               = 1'b1;
          cfg_store_update_o     = 1'b1;
          cfg_store_cntr_rst_o   = 1'b1;
          store_baseaddr_reset_o = 1'b1;
          if (kind.unit) begin
            state_d = unit_prep;
          end else if (kind.strided) begin
            state_d = strided_prep;
          end else if (kind.indexed) begin
            state_d = indexed_prep;
          end
        end
      end

      // Lanes fill the buffer, first read issued on the done cycle
      unit_prep, strided_prep, indexed_prep: begin
        sbuff_wen_o = vlane_store_valid_i;
        if (sbuff_write_done_i) begin
          sbuff_wen_o   = 1'b0;
          sbuff_ren_o   = 1'b1;
          tvalid_push_o = 1'b1;
          if (state_q == unit_prep) begin
            ctrl_wstart_o = 1'b1;
            state_d       = unit_tx;
          end else if (state_q == strided_prep) begin
            state_d = strided_tx_prep;
          end else begin
            state_d = indexed_tx_prep;
          end
        end
      end

      // Single burst, AXI back-pressure freezes the read pipe
      unit_tx: begin
        if (wr_tready_i) begin
          sbuff_ren_o   = ~sbuff_read_done_i;
          tvalid_push_o = ~sbuff_read_done_i;
        end else begin
          read_stall        = 1'b1;
          read_invalidate_o = 1'b1;
        end
        if (sbuff_read_done_i && ctrl_wdone_i) begin
          state_d = st_idle;
        end
      end

      // One burst per element
      strided_tx_prep, indexed_tx_prep: begin
        ctrl_wstart_o     = 1'b1;
        read_invalidate_o = 1'b1;
        sbuff_ren_o       = ~sbuff_read_done_i;
        tvalid_push_o     = ~sbuff_read_done_i;
        state_d = (state_q == strided_tx_prep) ? strided_tx : indexed_tx;
      end

      strided_tx, indexed_tx: begin
        // Hold the pending beat at the output until its burst ends
        read_stall        = stage_last_i;
        read_invalidate_o = ~wr_tready_i;
        if (ctrl_wdone_i) begin
          store_baseaddr_update_o = 1'b1;
          if (sbuff_read_done_i && drained_i) begin
            state_d = st_idle;
          end else if (state_q == strided_tx) begin
            state_d = strided_tx_prep;
          end else begin
            state_d = indexed_tx_prep;
          end
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign read_stall_o       = read_stall;
  assign sbuff_read_stall_o = read_stall;

endmodule : store_fsm

/* store_read_pipe.sv */
// Store buffer read valid pipeline
`timescale 1ns/1ps
`include "mcu_macros.svh"

module store_read_pipe (
  input  logic clk,
  input  logic rstn,
  input  logic tvalid_push_i,
  input  logic read_stall_i,
  input  logic read_invalidate_i,
  output logic wr_tvalid_o,
  output logic stage_last_o,
  output logic drained_o
);

  // One bit per cycle of buffer read latency
  logic [`MCU_RD_LAT-1:0] stage;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stage <= '0;
    end else if (!read_stall_i) begin
      stage <= {stage[`MCU_RD_LAT-2:0], tvalid_push_i};
    end
  end

  assign stage_last_o = stage[`MCU_RD_LAT-1];
  assign drained_o    = ~|stage;

  // Masked beat stays in the pipe and is replayed
  assign wr_tvalid_o  = stage_last_o & ~read_invalidate_i;

endmodule : store_read_pipe

/* tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held for 8 cycles, released just after an edge
  initial begin
    rstn_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #2 rstn_o = 1'b1;
  end

endmodule : tb_clk_gen

/* tb_m_cu.sv */
// Memory control unit store path testbench
`timescale 1ns/1ps
`include "mcu_macros.svh"

module tb_m_cu
  import vec_cfg_pkg::*;
  import store_ctrl_pkg::*;
();

  localparam int WR_BEATS   = 4;
  localparam int RD_BEATS   = 4;
  localparam int WDONE_DLY  = 3;
  // Five times the roughly 600 cycles the stores need
  localparam int MAX_CYCLES = 3000;
  localparam int SEED       = 32'h5071e5c8;

  logic        clk;
  logic        rstn;
  logic        mcu_st_vld_i;
  vcfg_t       mcu_sew_i;
  vcfg_t       mcu_lmul_i;
  vcfg_t       mcu_data_width_i;
  logic        mcu_unit_ld_st_i;
  logic        mcu_strided_ld_st_i;
  logic        mcu_idx_ld_st_i;
  logic        vlane_store_valid_i;
  logic        sbuff_write_done_i;
  logic        sbuff_read_done_i;
  logic        ctrl_wdone_i;
  logic        wr_tready_i;
  logic        mcu_st_rdy_o;
  vcfg_t       cfg_store_data_sew_o;
  vcfg_t       cfg_store_data_lmul_o;
  vcfg_t       cfg_store_idx_sew_o;
  vcfg_t       cfg_store_idx_lmul_o;
  store_kind_t store_type_o;
  logic        cfg_store_update_o;
  logic        cfg_store_cntr_rst_o;
  logic        store_baseaddr_reset_o;
  logic        store_baseaddr_update_o;
  logic        sbuff_wen_o;
  logic        sbuff_ren_o;
  logic        sbuff_read_stall_o;
  logic        ctrl_wstart_o;
  logic        wr_tvalid_o;

  // Responder and monitor state
  int   wen_cnt;
  int   ren_cnt;
  int   wdone_timer;
  int   wdone_cnt;
  int   wstart_cnt;
  int   update_cnt;
  int   cycles;
  int   checks;
  int   errors;
  logic wr_done_n;
  logic rd_done_n;
  logic wdone_n;
  logic in_prep;
  logic tvalid_seen;
  logic rd_done_seen;
  logic rdy_q;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  m_cu dut_i (.*);

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_vcfg(input string name, input vcfg_t exp, input vcfg_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_kind(input string name, input store_kind_t exp, input store_kind_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Expected EMUL built through the fields view
  function automatic vcfg_t expected_emul(input vcfg_t w, input vcfg_t l, input vcfg_t s);
    emul_addr_u a;
    int         lg;
    a.fields.width = w[1:0];
    a.fields.lmul  = l;
    a.fields.sew   = s[1:0];
    lg = int'($signed(a.fields.lmul)) + int'(a.fields.width) - int'(a.fields.sew);
    if (w < 3'd3 && s < 3'd3 && l != 3'd4 &&
        lg >= -`MCU_EMUL_LOG_MAX && lg <= `MCU_EMUL_LOG_MAX) begin
      return vcfg_t'(lg[2:0]);
    end
    return '0;
  endfunction

  ////////////////////////////////////////
  // Buffer and AXI responder
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!rstn || mcu_st_rdy_o) begin
      wen_cnt     = 0;
      ren_cnt     = 0;
      wdone_timer = 0;
      wr_done_n   = 1'b0;
      rd_done_n   = 1'b0;
      wdone_n     = 1'b0;
    end else begin
      if (sbuff_wen_o) wen_cnt++;
      // Write-done pulses once per store
      wr_done_n = (wen_cnt == WR_BEATS);
      if (wr_done_n) wen_cnt++;
      if (sbuff_ren_o) ren_cnt++;
      if (ren_cnt >= RD_BEATS) rd_done_n = 1'b1;
      if (ctrl_wstart_o) begin
        wdone_timer = WDONE_DLY;
        wdone_n     = 1'b0;
      end else if (wdone_timer > 0) begin
        wdone_timer--;
        if (wdone_timer == 0) begin
          wdone_n = 1'b1;
          wdone_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    #2;
    sbuff_write_done_i  = wr_done_n;
    sbuff_read_done_i   = rd_done_n;
    ctrl_wdone_i        = wdone_n;
    vlane_store_valid_i = (cycles % 3) != 0;
  end

  // Output monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rstn) begin
      if (mcu_st_rdy_o && !rdy_q && !rd_done_seen) begin
        errors++;
        $display("error: scheduler ready returned before the buffer gave read-done");
      end
      rdy_q = mcu_st_rdy_o;
      if (sbuff_read_done_i) rd_done_seen = 1'b1;
      if (ctrl_wstart_o) wstart_cnt++;
      if (store_baseaddr_update_o) update_cnt++;
      if (wr_tvalid_o && wr_tready_i) tvalid_seen = 1'b1;
      if (in_prep) begin
        if (sbuff_write_done_i) begin
          check_bit("prep wen at write-done", 1'b0, sbuff_wen_o);
          in_prep = 1'b0;
        end else begin
          check_bit("prep wen follows lanes", vlane_store_valid_i, sbuff_wen_o);
        end
      end
      if (cfg_store_update_o) in_prep = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("error: run stopped after %0d cycles without finishing", cycles);
      $display("checks %0d errors %0d", checks, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  // Issue a one-cycle request and check the save cycle and the capture
  task automatic issue_store(input string name, input store_kind_t kind,
                             input vcfg_t w, input vcfg_t l, input vcfg_t s);
    vcfg_t emul;
    emul = expected_emul(w, l, s);
    @(posedge clk);
    #2;
    mcu_st_vld_i        = 1'b1;
    mcu_unit_ld_st_i    = kind.unit;
    mcu_strided_ld_st_i = kind.strided;
    mcu_idx_ld_st_i     = kind.indexed;
    mcu_data_width_i    = w;
    mcu_lmul_i          = l;
    mcu_sew_i           = s;
    wstart_cnt   = 0;
    update_cnt   = 0;
    wdone_cnt    = 0;
    tvalid_seen  = 1'b0;
    rd_done_seen = 1'b0;
    @(posedge clk);
    #2;
    mcu_st_vld_i = 1'b0;
    @(negedge clk);
    check_bit({name, " cfg_update"}, 1'b1, cfg_store_update_o);
    check_bit({name, " cntr_rst"}, 1'b1, cfg_store_cntr_rst_o);
    check_bit({name, " baseaddr_reset"}, 1'b1, store_baseaddr_reset_o);
    @(negedge clk);
    check_bit({name, " cfg_update once"}, 1'b0, cfg_store_update_o);
    check_bit({name, " ready low"}, 1'b0, mcu_st_rdy_o);
    check_kind({name, " type"}, kind, store_type_o);
    check_vcfg({name, " idx_sew"}, w, cfg_store_idx_sew_o);
    check_vcfg({name, " idx_lmul"}, emul, cfg_store_idx_lmul_o);
    if (kind.indexed) begin
      check_vcfg({name, " data_sew"}, s, cfg_store_data_sew_o);
      check_vcfg({name, " data_lmul"}, l, cfg_store_data_lmul_o);
    end else begin
      check_vcfg({name, " data_sew"}, w, cfg_store_data_sew_o);
      check_vcfg({name, " data_lmul"}, emul, cfg_store_data_lmul_o);
    end
  endtask

  task automatic wait_ready();
    while (!mcu_st_rdy_o) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  task automatic reset_values();
    @(negedge clk);
    check_bit("reset ready", 1'b1, mcu_st_rdy_o);
    check_bit("reset cfg_update", 1'b0, cfg_store_update_o);
    check_bit("reset cntr_rst", 1'b0, cfg_store_cntr_rst_o);
    check_bit("reset baseaddr_reset", 1'b0, store_baseaddr_reset_o);
    check_bit("reset baseaddr_update", 1'b0, store_baseaddr_update_o);
    check_bit("reset wen", 1'b0, sbuff_wen_o);
    check_bit("reset ren", 1'b0, sbuff_ren_o);
    check_bit("reset stall", 1'b0, sbuff_read_stall_o);
    check_bit("reset wstart", 1'b0, ctrl_wstart_o);
    check_bit("reset tvalid", 1'b0, wr_tvalid_o);
    check_kind("reset type", '0, store_type_o);
    check_vcfg("reset data_sew", '0, cfg_store_data_sew_o);
    check_vcfg("reset data_lmul", '0, cfg_store_data_lmul_o);
    check_vcfg("reset idx_sew", '0, cfg_store_idx_sew_o);
    check_vcfg("reset idx_lmul", '0, cfg_store_idx_lmul_o);
  endtask

  task automatic unit_cfg_capture();
    store_kind_t k;
    vcfg_t       w;
    vcfg_t       l;
    vcfg_t       s;
    k      = '0;
    k.unit = 1'b1;
    repeat (20) begin
      w = vcfg_t'($urandom_range(3, 0));
      l = vcfg_t'($urandom_range(7, 0));
      s = vcfg_t'($urandom_range(3, 0));
      issue_store("unit_cfg", k, w, l, s);
      wait_ready();
    end
  endtask

  task automatic unit_store_flow();
    store_kind_t k;
    k      = '0;
    k.unit = 1'b1;
    issue_store("unit_flow", k, 3'd2, 3'd1, 3'd1);
    wait_ready();
    check_count("unit_flow wstart pulses", 1, wstart_cnt);
    check_count("unit_flow wdone responses", 1, wdone_cnt);
    check_bit("unit_flow tvalid seen", 1'b1, tvalid_seen);
  endtask

  // AXI stall while the single burst is under way
  task automatic backpressure_stall();
    store_kind_t k;
    k      = '0;
    k.unit = 1'b1;
    issue_store("backpressure", k, 3'd0, 3'd0, 3'd0);
    // Stall once a beat waits at the pipe output
    while (!wr_tvalid_o) @(negedge clk);
    @(posedge clk);
    #2;
    wr_tready_i = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("backpressure stall", 1'b1, sbuff_read_stall_o);
      check_bit("backpressure ren", 1'b0, sbuff_ren_o);
      check_bit("backpressure tvalid", 1'b0, wr_tvalid_o);
    end
    @(posedge clk);
    #2;
    wr_tready_i = 1'b1;
    tvalid_seen = 1'b0;
    wait_ready();
    check_bit("backpressure tvalid after release", 1'b1, tvalid_seen);
  endtask

  task automatic burst_updates(input string name, input logic indexed);
    store_kind_t k;
    vcfg_t       w;
    vcfg_t       l;
    vcfg_t       s;
    k         = '0;
    k.strided = ~indexed;
    k.indexed = indexed;
    w = vcfg_t'($urandom_range(2, 0));
    l = vcfg_t'($urandom_range(3, 0));
    s = vcfg_t'($urandom_range(2, 0));
    issue_store(name, k, w, l, s);
    wait_ready();
    check_count({name, " baseaddr updates"}, wdone_cnt, update_cnt);
    check_bit({name, " read-done seen"}, 1'b1, rd_done_seen);
  endtask

  initial begin
    void'($urandom(SEED));
    mcu_st_vld_i        = 1'b0;
    mcu_sew_i           = '0;
    mcu_lmul_i          = '0;
    mcu_data_width_i    = '0;
    mcu_unit_ld_st_i    = 1'b0;
    mcu_strided_ld_st_i = 1'b0;
    mcu_idx_ld_st_i     = 1'b0;
    vlane_store_valid_i = 1'b0;
    sbuff_write_done_i  = 1'b0;
    sbuff_read_done_i   = 1'b0;
    ctrl_wdone_i        = 1'b0;
    wr_tready_i         = 1'b1;
    wr_done_n    = 1'b0;
    rd_done_n    = 1'b0;
    wdone_n      = 1'b0;
    in_prep      = 1'b0;
    tvalid_seen  = 1'b0;
    rd_done_seen = 1'b0;
    rdy_q        = 1'b1;
    cycles       = 0;
    checks       = 0;
    errors       = 0;
    @(posedge rstn);
    reset_values();
    unit_cfg_capture();
    burst_updates("indexed", 1'b1);
    unit_store_flow();
    backpressure_stall();
    burst_updates("strided", 1'b0);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_m_cu

/* vec_cfg_pkg.sv */
// Vector configuration types
`include "mcu_macros.svh"

package vec_cfg_pkg;

  // SEW, LMUL, width or EMUL code
  // LMUL and EMUL are signed log2 codes, 4 is reserved
  typedef logic [`MCU_VCFG_W-1:0] vcfg_t;

  // Table address view of the EMUL inputs
  typedef struct packed {
    logic [1:0] width;
    logic [2:0] lmul;
    logic [1:0] sew;
  } emul_fields_t;

  // One word, decoded as fields or as a flat table index
  typedef union packed {
    emul_fields_t fields;
    logic [6:0]   index;
  } emul_addr_u;

endpackage : vec_cfg_pkg
